// ==== design/sq_settings.svh ====
`ifndef SQ_SETTINGS_SVH
`define SQ_SETTINGS_SVH

// number of store queue entries
// must be a power of two so the pointers wrap by plain addition
`define SQ_SZ 8

// bits to name one entry, log2 of SQ_SZ
`define SQ_IDX_BITS 3

// occupancy counters run from 0 up to SQ_SZ inclusive
`define SQ_CNT_BITS 4

// stores taken at dispatch and at retire per cycle
`define SQ_WIDTH_N 2

// holds a count from 0 up to SQ_WIDTH_N
`define SQ_N_BITS 2

`endif

// ==== design/lsq_pkg.sv ====
`default_nettype none
`include "sq_settings.svh"

package lsq_pkg;

    // wrap parity on top of the index
    // same index with opposite parity means the queue is full
    typedef struct packed {
        logic                    wrap;
        logic [`SQ_IDX_BITS-1:0] idx;
    } sq_pointer;

    // byte address, or word address plus offset for the forwarding compare
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [29:0] word_addr;
            logic [1:0]  offset;
        } word;
    } mem_addr;

    // store data seen as one word or as four byte lanes
    typedef union packed {
        logic [31:0]     whole;
        logic [3:0][7:0] bytes;
    } data_word;

    // one bit per byte lane of a word
    typedef logic [3:0] byte_mask;

    // one bit per queue entry
    typedef logic [`SQ_SZ-1:0] sq_mask;

    // resolved store coming from the store unit
    typedef struct packed {
        logic [`SQ_IDX_BITS-1:0] idx;
        mem_addr                 addr;
        data_word                data;
        byte_mask                mask;
    } sq_entry;

endpackage

`default_nettype wire

// ==== design/sq_pointers.sv ====
`default_nettype none
`include "sq_settings.svh"

module sq_pointers (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic [`SQ_N_BITS-1:0]  stores_dispatching,
    input  wire logic [`SQ_N_BITS-1:0]  num_store_retiring,
    input  wire logic                   store_req_accepted,
    input  wire logic                   restore_valid,
    input  wire lsq_pkg::sq_pointer     tail_restore,
    input  wire lsq_pkg::sq_mask        mask_restore,
    input  wire lsq_pkg::sq_mask        resolve_mask,
    input  wire lsq_pkg::sq_mask        dispatch_sq_mask,
    output lsq_pkg::sq_pointer          sq_tail,
    output lsq_pkg::sq_pointer          drain_head,
    output logic [`SQ_N_BITS-1:0]       sq_spots,
    output logic                        store_req_valid,
    output lsq_pkg::sq_mask             pending_mask
);

    // retire head marks the boundary between speculative and committed stores
    lsq_pkg::sq_pointer retire_head;
    lsq_pkg::sq_pointer next_tail;
    lsq_pkg::sq_pointer next_retire_head;
    lsq_pkg::sq_pointer next_drain_head;

    // occupancy counts every entry not yet accepted by the cache
    logic [`SQ_CNT_BITS-1:0] occupancy;
    logic [`SQ_CNT_BITS-1:0] next_occupancy;
    logic [`SQ_CNT_BITS-1:0] retired_cnt;
    logic [`SQ_CNT_BITS-1:0] next_retired_cnt;
    logic [`SQ_CNT_BITS-1:0] free_cnt;

    lsq_pkg::sq_mask mask_q;
    lsq_pkg::sq_mask next_mask;

    function automatic lsq_pkg::sq_pointer ptr_add(
        input lsq_pkg::sq_pointer      p,
        input logic [`SQ_N_BITS-1:0]   n
    );
        // parity flips on its own when the index wraps
        ptr_add = lsq_pkg::sq_pointer'(p + n);
    endfunction

    // entries from old up to young, a full lap counts as SQ_SZ
    function automatic logic [`SQ_CNT_BITS-1:0] ptr_dist(
        input lsq_pkg::sq_pointer young,
        input lsq_pkg::sq_pointer old
    );
        logic [`SQ_IDX_BITS-1:0] idx_diff;
        idx_diff = young.idx - old.idx;
        if (young.idx == old.idx && young.wrap != old.wrap) begin
            ptr_dist = `SQ_CNT_BITS'(`SQ_SZ);
        end else begin
            ptr_dist = `SQ_CNT_BITS'(idx_diff);
        end
    endfunction

    assign next_drain_head  = ptr_add(drain_head, `SQ_N_BITS'(store_req_accepted));
    assign next_retire_head = ptr_add(retire_head, num_store_retiring);
    assign next_tail        = restore_valid ? tail_restore : ptr_add(sq_tail, stores_dispatching);

    // registered so the cache request valid comes straight from a flop
    assign next_retired_cnt = ptr_dist(next_retire_head, next_drain_head);

    always_comb begin
        if (restore_valid) begin
            // squashed stores vanish, count what remains behind the restored tail
            next_occupancy = ptr_dist(tail_restore, next_drain_head);
        end else begin
            next_occupancy = occupancy + stores_dispatching - store_req_accepted;
        end
    end

    assign next_mask = restore_valid ? (mask_restore & ~resolve_mask) : dispatch_sq_mask;

    // stores resolving this cycle already drop out of the pending view
    assign pending_mask    = mask_q & ~resolve_mask;
    assign store_req_valid = retired_cnt != '0;

    assign free_cnt = `SQ_CNT_BITS'(`SQ_SZ) - occupancy;
    assign sq_spots = (free_cnt < `SQ_WIDTH_N) ? free_cnt[`SQ_N_BITS-1:0]
                                               : `SQ_N_BITS'(`SQ_WIDTH_N);

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_tail     <= '0;
            retire_head <= '0;
            drain_head  <= '0;
            occupancy   <= '0;
            retired_cnt <= '0;
            mask_q      <= '0;
        end else begin
            sq_tail     <= next_tail;
            retire_head <= next_retire_head;
            drain_head  <= next_drain_head;
            occupancy   <= next_occupancy;
            retired_cnt <= next_retired_cnt;
            mask_q      <= next_mask;
        end
    end

endmodule

`default_nettype wire

// ==== design/sq_entry_array.sv ====
`default_nettype none
`include "sq_settings.svh"

module sq_entry_array (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire lsq_pkg::sq_mask           resolve_mask,
    input  wire lsq_pkg::sq_entry          sq_packet,
    input  wire lsq_pkg::sq_pointer        drain_head,
    output lsq_pkg::sq_entry [`SQ_SZ-1:0]  entries,
    output lsq_pkg::mem_addr               store_req_addr,
    output lsq_pkg::data_word              store_req_data,
    output lsq_pkg::byte_mask              store_req_mask
);

    // entry at the drain head, the oldest store the cache has not taken
    lsq_pkg::sq_entry drain_entry;

    // a resolving store lands here at the edge
    // forwarding and the drain port see it one cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
        end else begin
            for (int i = 0; i < `SQ_SZ; i++) begin
                if (resolve_mask[i]) begin
                    entries[i] <= sq_packet;
                end
            end
        end
    end

    // only the index selects, the parity bit is for full/empty
    assign drain_entry = entries[drain_head.idx];

    // held steady while the cache stalls, since the drain head does not move
    assign store_req_addr = drain_entry.addr;
    assign store_req_data = drain_entry.data;
    assign store_req_mask = drain_entry.mask;

endmodule

`default_nettype wire

// ==== design/sq_forward.sv ====
`default_nettype none
`include "sq_settings.svh"

module sq_forward (
    input  wire lsq_pkg::sq_entry [`SQ_SZ-1:0] entries,
    input  wire lsq_pkg::sq_pointer            drain_head,
    input  wire lsq_pkg::sq_pointer            load_tail,
    input  wire lsq_pkg::mem_addr              load_addr,
    output lsq_pkg::data_word                  forward_data,
    output lsq_pkg::byte_mask                  forward_mask
);

    localparam int NUM_LANES = $bits(lsq_pkg::byte_mask);

    // entries holding the same word as the load
    logic [`SQ_SZ-1:0] word_hit;

    // rotated positions that lie between the drain head and the load tail
    logic [`SQ_SZ-1:0] live;

    // drain head position once the queue is rotated to start at load_tail
    logic [`SQ_IDX_BITS-1:0] oldest_pos;

    logic [NUM_LANES-1:0][7:0] lane_byte;
    logic [NUM_LANES-1:0]      lane_hit;

    always_comb begin
        for (int j = 0; j < `SQ_SZ; j++) begin
            word_hit[j] = entries[j].addr.word.word_addr == load_addr.word.word_addr;
        end
    end

    assign oldest_pos = drain_head.idx - load_tail.idx;

    // window is empty when the load saw no older undrained store
    // a full queue gives oldest_pos 0 with differing parity, so all stay live
    always_comb begin
        for (int k = 0; k < `SQ_SZ; k++) begin
            live[k] = (drain_head != load_tail) && (`SQ_IDX_BITS'(k) >= oldest_pos);
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic [`SQ_SZ-1:0]       byte_hit;
        logic [`SQ_SZ-1:0]       rotated;
        logic [`SQ_IDX_BITS-1:0] young_pos;
        logic [`SQ_IDX_BITS-1:0] young_idx;
        logic                    found;

        // same word and this lane written by the store
        always_comb begin
            for (int j = 0; j < `SQ_SZ; j++) begin
                byte_hit[j] = word_hit[j] && entries[j].mask[i];
            end
        end

        // position k is the entry k slots past load_tail
        // so the top position is the store right before the load
        always_comb begin
            for (int k = 0; k < `SQ_SZ; k++) begin
                rotated[k] = byte_hit[`SQ_IDX_BITS'(k) + load_tail.idx] && live[k];
            end
        end

        // highest set position wins, that is the youngest older store
        always_comb begin
            found     = 1'b0;
            young_pos = '0;
            for (int k = 0; k < `SQ_SZ; k++) begin
                if (rotated[k]) begin
                    found     = 1'b1;
                    young_pos = `SQ_IDX_BITS'(k);
                end
            end
        end

        // undo the rotation to get back the real entry index
        assign young_idx = young_pos + load_tail.idx;

        assign lane_hit[i]  = found;
        assign lane_byte[i] = found ? entries[young_idx].data.bytes[i] : 8'h00;
    end

    // lanes without a hit read zero, the load takes those bytes from the cache
    assign forward_data.bytes = lane_byte;
    assign forward_mask       = lane_hit;

endmodule

`default_nettype wire

// ==== design/store_queue.sv ====
`default_nettype none
`include "sq_settings.svh"

module store_queue (
    input  wire logic                   clock,
    input  wire logic                   reset,

    // store unit
    input  wire lsq_pkg::sq_entry       sq_packet,
    input  wire lsq_pkg::sq_mask        resolve_mask,

    // dispatch
    input  wire logic [`SQ_N_BITS-1:0]  stores_dispatching,
    input  wire lsq_pkg::sq_mask        dispatch_sq_mask,
    output logic [`SQ_N_BITS-1:0]       sq_spots,
    output lsq_pkg::sq_pointer          sq_tail,
    output lsq_pkg::sq_mask             pending_mask,

    // load unit
    input  wire lsq_pkg::sq_pointer     load_tail,
    input  wire lsq_pkg::mem_addr       load_addr,
    output lsq_pkg::data_word           forward_data,
    output lsq_pkg::byte_mask           forward_mask,

    // branch stack
    input  wire logic                   restore_valid,
    input  wire lsq_pkg::sq_pointer     tail_restore,
    input  wire lsq_pkg::sq_mask        mask_restore,

    // data cache
    input  wire logic                   store_req_accepted,
    output logic                        store_req_valid,
    output lsq_pkg::mem_addr            store_req_addr,
    output lsq_pkg::data_word           store_req_data,
    output lsq_pkg::byte_mask           store_req_mask,

    // retire
    input  wire logic [`SQ_N_BITS-1:0]  num_store_retiring
);

    lsq_pkg::sq_pointer            drain_head;
    lsq_pkg::sq_entry [`SQ_SZ-1:0] entries;

    sq_pointers u_pointers (
        .clock              (clock),
        .reset              (reset),
        .stores_dispatching (stores_dispatching),
        .num_store_retiring (num_store_retiring),
        .store_req_accepted (store_req_accepted),
        .restore_valid      (restore_valid),
        .tail_restore       (tail_restore),
        .mask_restore       (mask_restore),
        .resolve_mask       (resolve_mask),
        .dispatch_sq_mask   (dispatch_sq_mask),
        .sq_tail            (sq_tail),
        .drain_head         (drain_head),
        .sq_spots           (sq_spots),
        .store_req_valid    (store_req_valid),
        .pending_mask       (pending_mask)
    );

    sq_entry_array u_entries (
        .clock          (clock),
        .reset          (reset),
        .resolve_mask   (resolve_mask),
        .sq_packet      (sq_packet),
        .drain_head     (drain_head),
        .entries        (entries),
        .store_req_addr (store_req_addr),
        .store_req_data (store_req_data),
        .store_req_mask (store_req_mask)
    );

    // stores stay searchable until the cache takes them
    sq_forward u_forward (
        .entries      (entries),
        .drain_head   (drain_head),
        .load_tail    (load_tail),
        .load_addr    (load_addr),
        .forward_data (forward_data),
        .forward_mask (forward_mask)
    );

endmodule

`default_nettype wire

// ==== test/sq_ref_model.svh ====
`ifndef SQ_REF_MODEL_SVH
`define SQ_REF_MODEL_SVH

// model of queue pointers, entry contents and the registered mask
logic [3:0]  m_tail;
logic [3:0]  m_retire;
logic [3:0]  m_drain;
logic [7:0]  m_mask;
logic        m_valid;
logic [31:0] m_addr [8];
logic [31:0] m_data [8];
logic [3:0]  m_bmask [8];
logic        m_resolved [8];
int          acc_count;
int          retired_total;

// entries from old up to young, a full lap is 8
function automatic int ref_dist(input logic [3:0] young, input logic [3:0] old);
    logic [2:0] diff;
    diff = young[2:0] - old[2:0];
    if (young[2:0] == old[2:0] && young[3] != old[3]) begin
        return 8;
    end
    return int'(diff);
endfunction

function automatic int model_spots();
    int free_cnt;
    free_cnt = 8 - ref_dist(m_tail, m_drain);
    return (free_cnt < 2) ? free_cnt : 2;
endfunction

// youngest older store per byte lane, walking back from the load tail
function automatic logic [35:0] ref_forward(input logic [3:0] ltail, input logic [31:0] laddr);
    logic [31:0] d;
    logic [3:0]  m;
    logic [2:0]  idx;
    int          n;
    d = '0;
    m = '0;
    n = ref_dist(ltail, m_drain);
    for (int k = 1; k <= n; k++) begin
        idx = ltail[2:0] - 3'(k);
        for (int b = 0; b < 4; b++) begin
            if (!m[b] && m_addr[idx][31:2] == laddr[31:2] && m_bmask[idx][b]) begin
                m[b]        = 1'b1;
                d[8*b +: 8] = m_data[idx][8*b +: 8];
            end
        end
    end
    return {m, d};
endfunction

`endif

// ==== test/store_queue_tb.sv ====
`default_nettype none
`include "sq_settings.svh"

module store_queue_tb;
    timeunit 1ns;
    timeprecision 100ps;

`include "sq_ref_model.svh"

    logic clock = 1'b0;
    logic reset;
    lsq_pkg::sq_entry    sq_packet;
    lsq_pkg::sq_mask     resolve_mask;
    logic [1:0]          stores_dispatching;
    lsq_pkg::sq_mask     dispatch_sq_mask;
    logic [1:0]          sq_spots;
    lsq_pkg::sq_pointer  sq_tail;
    lsq_pkg::sq_mask     pending_mask;
    lsq_pkg::sq_pointer  load_tail;
    lsq_pkg::mem_addr    load_addr;
    lsq_pkg::data_word   forward_data;
    lsq_pkg::byte_mask   forward_mask;
    logic                restore_valid;
    lsq_pkg::sq_pointer  tail_restore;
    lsq_pkg::sq_mask     mask_restore;
    logic                store_req_accepted;
    logic                store_req_valid;
    lsq_pkg::mem_addr    store_req_addr;
    lsq_pkg::data_word   store_req_data;
    lsq_pkg::byte_mask   store_req_mask;
    logic [1:0]          num_store_retiring;

    integer seed = 32'h37ac;
    logic   checking = 1'b0;
    logic   prev_valid = 1'b0;
    logic   prev_acc = 1'b0;
    logic [67:0] prev_req;
    int     waited;

    store_queue uut (.*);

    always #4 clock = ~clock;

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic compare_value(input string name, input logic [67:0] exp, input logic [67:0] act);
        assert (exp === act) else begin
            $display("ERR time %0t %s expected %h actual %h", $time, name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // apply what the DUT sampled at this edge to the model
    task automatic step_model();
        logic [3:0] p;
        for (int i = 0; i < 8; i++) begin
            if (resolve_mask[i]) begin
                m_addr[i]     = sq_packet.addr.raw;
                m_data[i]     = sq_packet.data.whole;
                m_bmask[i]    = sq_packet.mask;
                m_resolved[i] = 1'b1;
            end
        end
        if (store_req_accepted) begin
            m_drain = m_drain + 4'd1;
        end
        m_retire      = m_retire + 4'(num_store_retiring);
        retired_total = retired_total + int'(num_store_retiring);
        if (restore_valid) begin
            m_tail = tail_restore;
            m_mask = mask_restore & ~resolve_mask;
        end else begin
            for (int i = 0; i < int'(stores_dispatching); i++) begin
                p = m_tail + 4'(i);
                m_resolved[p[2:0]] = 1'b0;
            end
            m_tail = m_tail + 4'(stores_dispatching);
            m_mask = dispatch_sq_mask;
        end
        m_valid = ref_dist(m_retire, m_drain) != 0;
    endtask

    task automatic drive_inputs(input logic draining, input int stall);
        logic [3:0] p;
        int         span;
        int         n_ok;
        restore_valid      <= 1'b0;
        resolve_mask       <= '0;
        stores_dispatching <= 2'd0;
        num_store_retiring <= 2'd0;
        span = ref_dist(m_tail, m_retire);
        // a store may resolve in the same cycle as a restore
        if (span > 0) begin
            p = m_retire + 4'(rnd(span));
            if (!m_resolved[p[2:0]]) begin
                resolve_mask            <= 8'd1 << p[2:0];
                sq_packet.idx           <= p[2:0];
                sq_packet.addr.raw      <= {28'h0, 2'(rnd(4)), 2'(rnd(4))};
                sq_packet.data.whole    <= 32'($random(seed));
                sq_packet.mask          <= 4'(rnd(16));
            end
        end
        if (!draining && rnd(16) == 0) begin
            restore_valid <= 1'b1;
            // a full queue restored onto its own tail keeps all entries
            if (ref_dist(m_tail, m_drain) == 8 && rnd(2) == 0) begin
                tail_restore <= m_tail;
            end else begin
                tail_restore <= m_retire + 4'(rnd(span + 1));
            end
            mask_restore <= 8'(rnd(256));
        end else begin
            if (!draining) begin
                stores_dispatching <= 2'(rnd(model_spots() + 1));
                dispatch_sq_mask   <= 8'(rnd(256));
            end
            n_ok = 0;
            while (n_ok < 2 && n_ok < span && m_resolved[3'(m_retire[2:0] + 3'(n_ok))]) begin
                n_ok++;
            end
            num_store_retiring <= 2'(rnd(n_ok + 1));
        end
        store_req_accepted <= m_valid && (rnd(4) < stall);
        load_tail          <= m_drain + 4'(rnd(ref_dist(m_tail, m_drain) + 1));
        load_addr.raw      <= {28'h0, 2'(rnd(4)), 2'(rnd(4))};
    endtask

    // outputs are settled by the falling edge
    always @(negedge clock) begin : compare_outputs
        logic [35:0] exp_fwd;
        logic [2:0]  d;
        if (checking) begin
            exp_fwd = ref_forward(load_tail, load_addr.raw);
            d = m_drain[2:0];
            compare_value("sq_tail", 68'(m_tail), 68'(sq_tail));
            compare_value("sq_spots", 68'(model_spots()), 68'(sq_spots));
            compare_value("store_req_valid", 68'(m_valid), 68'(store_req_valid));
            compare_value("pending_mask", 68'(m_mask & ~resolve_mask), 68'(pending_mask));
            compare_value("forward_data", 68'(exp_fwd[31:0]), 68'(forward_data.whole));
            compare_value("forward_mask", 68'(exp_fwd[35:32]), 68'(forward_mask));
            if (m_valid) begin
                compare_value("store_req_addr", 68'(m_addr[d]), 68'(store_req_addr.raw));
                compare_value("store_req_data", 68'(m_data[d]), 68'(store_req_data.whole));
                compare_value("store_req_mask", 68'(m_bmask[d]), 68'(store_req_mask));
            end
            if (prev_valid && !prev_acc) begin
                compare_value("stalled request",
                              prev_req, {store_req_addr, store_req_data, store_req_mask});
            end
            // one store goes to the cache in each cycle with valid and accepted high
            if (store_req_valid && store_req_accepted) begin
                acc_count++;
            end
            prev_valid = store_req_valid;
            prev_acc   = store_req_accepted;
            prev_req   = {store_req_addr, store_req_data, store_req_mask};
        end
    end

    initial begin
        reset              <= 1'b1;
        sq_packet          <= '0;
        resolve_mask       <= '0;
        stores_dispatching <= 2'd0;
        dispatch_sq_mask   <= '0;
        load_tail          <= '0;
        load_addr          <= '0;
        restore_valid      <= 1'b0;
        tail_restore       <= '0;
        mask_restore       <= '0;
        store_req_accepted <= 1'b0;
        num_store_retiring <= 2'd0;
        m_tail = '0;
        m_retire = '0;
        m_drain = '0;
        m_mask = '0;
        m_valid = 1'b0;
        acc_count = 0;
        retired_total = 0;
        for (int i = 0; i < 8; i++) begin
            m_addr[i] = '0;
            m_data[i] = '0;
            m_bmask[i] = '0;
            m_resolved[i] = 1'b0;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        checking = 1'b1;
        // long accept stalls alternate with free draining so the queue fills up
        for (int cyc = 0; cyc < 2000; cyc++) begin
            @(posedge clock);
            step_model();
            drive_inputs(1'b0, ((cyc / 200) % 2 == 1) ? 0 : 3);
        end
        waited = 0;
        while (!(m_retire == m_tail && m_drain == m_tail)) begin
            @(posedge clock);
            step_model();
            drive_inputs(1'b1, 3);
            waited++;
            if (waited > 400) begin
                $display("timeout: queue did not retire and drain all stores");
                $display("Something failed");
                $fatal(1);
            end
        end
        if (acc_count == retired_total) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("ERR time %0t request count expected %0d actual %0d",
                     $time, retired_total, acc_count);
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
+incdir+test
design/lsq_pkg.sv
design/sq_pointers.sv
design/sq_entry_array.sv
design/sq_forward.sv
design/store_queue.sv
test/store_queue_tb.sv

// ==== Makefile ====
# Verilator build for the store queue testbench

VERILATOR ?= verilator
TOP       ?= store_queue_tb
RTL_TOP   ?= store_queue
FLIST     ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# pass only when the testbench prints the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
